//--- Makefile
# Verilator build and run for the Tron system testbench.

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module tronTb -f sources.f -o tronSim
	@out="$$(./obj_dir/tronSim)"; echo "$$out"; echo "$$out" | grep -q "^TEST PASS$$"

lint:
	verilator --lint-only --timing -Wall --top-module tronTb -f sources.f

clean:
	rm -rf obj_dir

//--- sources.f
verilog/tronPkg.sv
verilog/cpuCtrlIf.sv
verilog/memBusIf.sv
verilog/cpuController.sv
verilog/cpuDatapath.sv
verilog/sharedMemory.sv
verilog/videoTiming.sv
verilog/pixelGen.sv
verilog/tronTop.sv
+incdir+test
test/tronTb.sv

//--- test/program.hex
// Tron demo program, one instruction word per line from address 0.
// Word layout: opcode, rd, then rs and a spare nibble or an 8-bit immediate.
73FF // LUI   r3, 0xFF
63FF // ADDI  r3, 0xFF      r3 = switch word address
74FF // LUI   r4, 0xFF
64FE // ADDI  r4, 0xFE      r4 = audio word address
7501 // LUI   r5, 0x01      r5 = framebuffer base
6601 // ADDI  r6, 0x01      r6 = shift amount
67A5 // ADDI  r7, 0xA5      r7 = audio mask
8130 // LOAD  r1, [r3]      loop: read the switches
7200 // LUI   r2, 0x00
3210 // OR    r2, r1
5260 // SHL   r2, r6
4270 // XOR   r2, r7
9240 // STORE r2, [r4]      audio word
9150 // STORE r1, [r5]      first framebuffer word
A007 // JMP   7

//--- test/tronModel.svh
/*
 * Tron reference model.
 * Galois LFSR for the switch stimulus and the expected
 * audio word and pixel colours of the demo program.
 */
`ifndef TRON_MODEL_SVH
`define TRON_MODEL_SVH

localparam logic [15:0] LFSR_SEED = 16'd8882;
localparam logic [15:0] LFSR_TAPS = 16'hB400;
localparam logic [23:0] COLOUR_WHITE = 24'hFFFFFF;
localparam logic [23:0] COLOUR_BACKGROUND = 24'h000040;

logic [15:0] lfsrState;

// One Galois step, taps for x^16 + x^14 + x^13 + x^11 + 1.
function automatic logic [15:0] lfsrNext(input logic [15:0] state);
	logic [15:0] next;
	next = state >> 1;
	if (state[0]) begin
		next = next ^ LFSR_TAPS;
	end
	return next;
endfunction

// One LFSR step per switch bit.
task automatic drawSwitches(output logic [9:0] value);
	for (int i = 0; i < 10; i++) begin
		lfsrState = lfsrNext(lfsrState);
		value[i] = lfsrState[0];
	end
endtask

// Switches shifted left by one, then masked with 0x00A5.
function automatic logic [15:0] expectedAudio(input logic [9:0] sw);
	return {5'b00000, sw, 1'b0} ^ 16'h00A5;
endfunction

// Line 0 pixel x shows bit (15 - x) of the first framebuffer word.
function automatic logic [23:0] expectedPixel(input logic [9:0] sw, input int x);
	logic [15:0] fbWord;
	logic [3:0] bitIndex;
	fbWord = {6'b000000, sw};
	bitIndex = 4'(15 - x);
	if (fbWord[bitIndex]) begin
		return COLOUR_WHITE;
	end
	return COLOUR_BACKGROUND;
endfunction

`endif

//--- test/tronTb.sv
/*
 * Tron system testbench.
 * Random switch holds from an LFSR, audio word checks against
 * the model, and a pixel monitor for sync, blanking and the
 * framebuffer contents on the VGA outputs.
 */
`timescale 1ns/1ps

module tronTb;
	localparam int H_ACTIVE = 32;
	localparam int H_FRONT = 2;
	localparam int H_SYNC = 4;
	localparam int H_BACK = 2;
	localparam int V_ACTIVE = 4;
	localparam int V_FRONT = 1;
	localparam int V_SYNC = 2;
	localparam int V_BACK = 1;
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int LINE_CLOCKS = 2 * H_TOTAL;
	localparam int FRAME_CLOCKS = LINE_CLOCKS * V_TOTAL;
	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_HOLDS = 20;
	// Enough for the program loop to pick up new switches and redraw.
	localparam int SETTLE_CYCLES = 100;
	// Two frames per hold, so a complete frame always follows the redraw.
	localparam int HOLD_CYCLES = 2 * FRAME_CLOCKS + SETTLE_CYCLES;
	// From the vsync edge to the end of line 0.
	localparam int LINE0_SPAN = (V_SYNC + V_BACK + 1) * LINE_CLOCKS + 8;
	localparam int TIMEOUT_NS = (NUM_HOLDS * HOLD_CYCLES + RESET_CYCLES + 200) * CLK_PERIOD;

	logic clk;
	logic rstN;
	logic [9:0] switches;
	logic [15:0] audioOut;
	logic vgaHs;
	logic vgaVs;
	logic vgaClk;
	logic vgaSyncN;
	logic vgaBlankN;
	logic [7:0] vgaR;
	logic [7:0] vgaG;
	logic [7:0] vgaB;

	int errors;
	int checks;
	int framesChecked;

	// Pixel monitor state.
	logic prevHs;
	logic prevVs;
	logic prevBlankN;
	logic hsSeen;
	logic vsSeen;
	logic lineValid;
	logic frameCheck;
	int hsLowPixels;
	int hsPeriodPixels;
	int vsLowPixels;
	int visPixels;
	int visLine;
	int visLinesInFrame;

	`include "tronModel.svh"

	tronTop #(
		.MEM_WORDS(512),
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
	) dut_i (
		.clk(clk), .rstN(rstN), .switches(switches), .audioOut(audioOut),
		.vgaHs(vgaHs), .vgaVs(vgaVs), .vgaClk(vgaClk), .vgaSyncN(vgaSyncN),
		.vgaBlankN(vgaBlankN), .vgaR(vgaR), .vgaG(vgaG), .vgaB(vgaB)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Ends a stuck run well after the last hold.
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("TEST FAIL");
		$finish;
	end

	task automatic compareValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
		end
	endtask

	task automatic reportFailure(input string message);
		errors++;
		$display("%s", message);
	endtask

	// One call per pixel, in the first clock after the outputs update.
	task automatic sampleVideo(input logic [9:0] sw, input int holdCycle);
		logic [23:0] rgb;
		rgb = {vgaR, vgaG, vgaB};
		compareValue("syncN", 32'(vgaHs & vgaVs), 32'(vgaSyncN));

		// Horizontal sync width and period.
		if (!prevHs && vgaHs && hsSeen) begin
			compareValue("hsync width", H_SYNC, hsLowPixels);
		end
		if (prevHs && !vgaHs) begin
			if (hsSeen) begin
				compareValue("hsync period", H_TOTAL, hsPeriodPixels);
			end
			hsSeen = 1'b1;
			hsLowPixels = 0;
			hsPeriodPixels = 0;
		end
		hsPeriodPixels++;
		if (!vgaHs) begin
			hsLowPixels++;
		end

		// Vertical sync width, and the frame boundary.
		if (!prevVs && vgaVs && vsSeen) begin
			compareValue("vsync width", V_SYNC * H_TOTAL, vsLowPixels);
		end
		if (prevVs && !vgaVs) begin
			if (vsSeen) begin
				compareValue("visible lines", V_ACTIVE, visLinesInFrame);
			end
			vsSeen = 1'b1;
			vsLowPixels = 0;
			visLine = -1;
			visLinesInFrame = 0;
			// Line 0 is only judged when it falls in the settled part of the hold.
			frameCheck = (holdCycle >= SETTLE_CYCLES) && (holdCycle + LINE0_SPAN < HOLD_CYCLES);
			if (frameCheck) begin
				framesChecked++;
			end
		end
		if (!vgaVs) begin
			vsLowPixels++;
		end

		// Visible area.
		if (vgaBlankN) begin
			if (!prevBlankN && vsSeen) begin
				lineValid = 1'b1;
				visLine++;
				visLinesInFrame++;
				visPixels = 0;
			end
			if (lineValid) begin
				if (visLine == 0 && visPixels < 16) begin
					if (frameCheck) begin
						compareValue("line 0 pixel", 32'(expectedPixel(sw, visPixels)), 32'(rgb));
					end
				end else begin
					compareValue("background pixel", 32'(COLOUR_BACKGROUND), 32'(rgb));
				end
				visPixels++;
			end
		end else begin
			if (prevBlankN && lineValid) begin
				compareValue("visible pixels per line", H_ACTIVE, visPixels);
				lineValid = 1'b0;
			end
			compareValue("blanked rgb", 32'h0, 32'(rgb));
		end

		prevHs = vgaHs;
		prevVs = vgaVs;
		prevBlankN = vgaBlankN;
	endtask

	initial begin
		logic [9:0] sw;
		logic pixClkPrev;
		errors = 0;
		checks = 0;
		framesChecked = 0;
		lfsrState = LFSR_SEED;
		rstN = 1'b0;
		switches = '0;

		// Reset state of the outputs.
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		compareValue("reset audioOut", 32'h0, 32'(audioOut));
		compareValue("reset blankN", 32'h0, 32'(vgaBlankN));
		compareValue("reset rgb", 32'h0, 32'({vgaR, vgaG, vgaB}));
		compareValue("reset hsync", 32'h1, 32'(vgaHs));
		compareValue("reset vsync", 32'h1, 32'(vgaVs));
		rstN = 1'b1;

		// The first store comes well after these cycles.
		for (int c = 0; c < 12; c++) begin
			@(negedge clk);
			if (c == 0) begin
				compareValue("blankN after reset", 32'h0, 32'(vgaBlankN));
			end
			compareValue("audioOut before store", 32'h0, 32'(audioOut));
			compareValue("hsync after reset", 32'h1, 32'(vgaHs));
			compareValue("vsync after reset", 32'h1, 32'(vgaVs));
		end

		// Monitor starts from the outputs as they are now.
		prevHs = vgaHs;
		prevVs = vgaVs;
		prevBlankN = vgaBlankN;
		pixClkPrev = vgaClk;
		hsSeen = 1'b0;
		vsSeen = 1'b0;
		lineValid = 1'b0;
		frameCheck = 1'b0;
		hsLowPixels = 0;
		hsPeriodPixels = 0;
		vsLowPixels = 0;
		visPixels = 0;
		visLine = -1;
		visLinesInFrame = 0;

		for (int h = 0; h < NUM_HOLDS; h++) begin
			drawSwitches(sw);
			switches = sw;
			framesChecked = 0;
			for (int c = 0; c < HOLD_CYCLES; c++) begin
				@(negedge clk);
				// Pixel clock runs at half the system clock.
				compareValue("pixel clock", 32'(!pixClkPrev), 32'(vgaClk));
				pixClkPrev = vgaClk;
				// Low pixel clock means the outputs just took a new pixel.
				if (!vgaClk) begin
					sampleVideo(sw, c);
				end
			end
			compareValue("audioOut", 32'(expectedAudio(sw)), 32'(audioOut));
			if (framesChecked == 0) begin
				reportFailure("No settled frame was seen during a switch hold");
			end
		end

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

//--- verilog/cpuController.sv
/*
 * Tron processor controller.
 * Fetch, execute and memory state machine, instruction
 * register and opcode decode into datapath control levels.
 */
`timescale 1ns/1ps

module cpuController (
	input logic clk,
	input logic rstN,
	memBusIf.fetch bus,
	cpuCtrlIf.ctrl ctrl
);
	import tronPkg::*;

	typedef enum logic [1:0] {FETCH, EXECUTE, MEM} state_t;

	state_t state;
	state_t stateNext;
	instrWord_t instrReg;
	instrWord_t instr;
	opcode_t opcode;

	// Word arrives from memory in EXECUTE and is decoded right away.
	assign instr = (state == EXECUTE) ? bus.rdata : instrReg;
	assign opcode = instr.rType.opcode;

	// Register fields from the R view, immediate from the I view.
	assign ctrl.rd = instr.rType.rd;
	assign ctrl.rs = instr.rType.rs;
	assign ctrl.imm = instr.iType.imm;

	always_ff @(posedge clk) begin
		if (state == EXECUTE) begin
			instrReg <= bus.rdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= FETCH;
		end else begin
			state <= stateNext;
		end
	end

	always_comb begin
		stateNext = FETCH;
		case (state)
			FETCH: stateNext = EXECUTE;
			EXECUTE: begin
				// Only memory instructions need the third cycle.
				if (opcode == OP_LOAD || opcode == OP_STORE) begin
					stateNext = MEM;
				end
			end
			default: stateNext = FETCH;
		endcase
	end

	always_comb begin
		ctrl.aluOp = ALU_ADD;
		ctrl.immSel = 1'b0;
		ctrl.regWrite = 1'b0;
		ctrl.flagWrite = 1'b0;
		ctrl.memWrite = 1'b0;
		ctrl.memRead = 1'b0;
		ctrl.pcIncrement = 1'b0;
		ctrl.pcJump = 1'b0;
		ctrl.pcBranch = 1'b0;
		ctrl.fetchPhase = 1'b0;
		case (state)
			FETCH: begin
				// PC on the bus, then step past this word.
				ctrl.fetchPhase = 1'b1;
				ctrl.pcIncrement = 1'b1;
			end
			EXECUTE: begin
				case (opcode)
					OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL: begin
						ctrl.regWrite = 1'b1;
						ctrl.flagWrite = 1'b1;
						case (opcode)
							OP_SUB: ctrl.aluOp = ALU_SUB;
							OP_AND: ctrl.aluOp = ALU_AND;
							OP_OR: ctrl.aluOp = ALU_OR;
							OP_XOR: ctrl.aluOp = ALU_XOR;
							OP_SHL: ctrl.aluOp = ALU_SHL;
							default: ctrl.aluOp = ALU_ADD;
						endcase
					end
					OP_ADDI: begin
						ctrl.immSel = 1'b1;
						ctrl.regWrite = 1'b1;
						ctrl.flagWrite = 1'b1;
					end
					OP_LUI: begin
						ctrl.immSel = 1'b1;
						ctrl.regWrite = 1'b1;
						ctrl.aluOp = ALU_LUI;
					end
					OP_JMP: ctrl.pcJump = 1'b1;
					// Datapath decides whether the branch is taken.
					OP_BEQ: ctrl.pcBranch = 1'b1;
					default: ;
				endcase
			end
			MEM: begin
				if (opcode == OP_LOAD) begin
					ctrl.memRead = 1'b1;
					ctrl.regWrite = 1'b1;
				end else begin
					ctrl.memWrite = 1'b1;
				end
			end
			default: ;
		endcase
	end

	// FSM stays in its three states.
	assert property (@(posedge clk) disable iff (!rstN)
		state inside {FETCH, EXECUTE, MEM});

endmodule

//--- verilog/cpuCtrlIf.sv
/*
 * Controller to datapath bundle.
 * Control levels and decoded instruction fields, valid for
 * the cycle of the state that asserts them.
 */
`timescale 1ns/1ps

interface cpuCtrlIf;
	import tronPkg::*;

	aluOp_t aluOp;
	logic immSel;
	logic regWrite;
	logic flagWrite;
	logic memWrite;
	logic memRead;
	logic pcIncrement;
	logic pcJump;
	logic pcBranch;
	logic fetchPhase;
	logic [3:0] rd;
	logic [3:0] rs;
	logic [7:0] imm;

	modport ctrl (output aluOp, immSel, regWrite, flagWrite, memWrite, memRead,
		pcIncrement, pcJump, pcBranch, fetchPhase, rd, rs, imm);
	modport dp (input aluOp, immSel, regWrite, flagWrite, memWrite, memRead,
		pcIncrement, pcJump, pcBranch, fetchPhase, rd, rs, imm);
endinterface

//--- verilog/cpuDatapath.sv
/*
 * Tron processor datapath.
 * Sixteen registers, ALU with zero flag, program counter and
 * the memory address and write data selection.
 */
`timescale 1ns/1ps

module cpuDatapath (
	input logic clk,
	input logic rstN,
	cpuCtrlIf.dp ctrl,
	memBusIf.master bus
);
	import tronPkg::*;

	logic [15:0] regFile [16];
	logic [15:0] pc;
	logic zeroFlag;
	logic [15:0] regA;
	logic [15:0] regB;
	logic [15:0] aluB;
	logic [15:0] aluResult;
	logic [15:0] writeData;
	logic [15:0] branchOffset;
	logic branchTaken;

	// Destination is also the first operand and the store data.
	assign regA = regFile[ctrl.rd];
	assign regB = regFile[ctrl.rs];

	// Immediate is zero-extended for ADDI and LUI.
	assign aluB = ctrl.immSel ? {8'h00, ctrl.imm} : regB;

	always_comb begin
		case (ctrl.aluOp)
			ALU_ADD: aluResult = regA + aluB;
			ALU_SUB: aluResult = regA - aluB;
			ALU_AND: aluResult = regA & aluB;
			ALU_OR: aluResult = regA | aluB;
			ALU_XOR: aluResult = regA ^ aluB;
			ALU_SHL: aluResult = regA << aluB[3:0];
			ALU_LUI: aluResult = {aluB[7:0], 8'h00};
			default: aluResult = '0;
		endcase
	end

	// Load data or ALU result into the register file.
	assign writeData = ctrl.memRead ? bus.rdata : aluResult;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 16; i++) begin
				regFile[i] <= '0;
			end
		end else if (ctrl.regWrite && ctrl.rd != 4'd0) begin
			// r0 is never written, so it always reads zero.
			regFile[ctrl.rd] <= writeData;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			zeroFlag <= 1'b0;
		end else if (ctrl.flagWrite) begin
			zeroFlag <= (aluResult == 16'h0000);
		end
	end

	// Branch offset is signed and relative to the next instruction.
	assign branchOffset = {{8{ctrl.imm[7]}}, ctrl.imm};
	assign branchTaken = ctrl.pcBranch && zeroFlag;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= '0;
		end else if (ctrl.pcIncrement) begin
			pc <= pc + 16'd1;
		end else if (ctrl.pcJump) begin
			pc <= {8'h00, ctrl.imm};
		end else if (branchTaken) begin
			pc <= pc + branchOffset;
		end
	end

	// PC while fetching, source register otherwise.
	assign bus.addr = ctrl.fetchPhase ? pc : regB;
	assign bus.wdata = regA;
	assign bus.we = ctrl.memWrite;

endmodule

//--- verilog/memBusIf.sv
/*
 * Processor port of the shared memory.
 * Synchronous read, rdata follows addr by one clock.
 */
`timescale 1ns/1ps

interface memBusIf;
	logic [15:0] addr;
	logic [15:0] wdata;
	logic we;
	logic [15:0] rdata;

	// Datapath side.
	modport master (output addr, wdata, we, input rdata);
	// Controller only watches the returned instruction.
	modport fetch (input rdata);
	// Memory side.
	modport slave (input addr, wdata, we, output rdata);
endinterface

//--- verilog/pixelGen.sv
/*
 * Pixel generator.
 * Maps the counters to a framebuffer word, picks the bit for
 * the pixel and drives one-bit colour with delayed sync.
 */
`timescale 1ns/1ps

module pixelGen #(
	parameter int H_ACTIVE = 640,
	parameter int V_ACTIVE = 480
) (
	input logic clk,
	input logic rstN,
	input logic pixelEn,
	input logic [15:0] hCount,
	input logic [15:0] vCount,
	input logic bright,
	input logic hSync,
	input logic vSync,
	output logic [15:0] vidAddr,
	input logic [15:0] vidData,
	output logic [7:0] vgaR,
	output logic [7:0] vgaG,
	output logic [7:0] vgaB,
	output logic vgaHs,
	output logic vgaVs,
	output logic vgaSyncN,
	output logic vgaBlankN
);
	import tronPkg::*;

	localparam logic [7:0] BG_BLUE = 8'h40;

	logic inFrame;
	logic [15:0] pixelIndex;
	logic [3:0] bitSel;
	logic pixelOn;

	assign inFrame = (hCount < 16'(H_ACTIVE)) && (vCount < 16'(V_ACTIVE));
	assign pixelIndex = 16'(vCount * H_ACTIVE) + hCount;

	// Memory samples the address in the first half of the pixel.
	assign vidAddr = inFrame ? fbBase + (pixelIndex >> 4) : fbBase;

	// Leftmost pixel is the word's MSB.
	assign bitSel = ~hCount[3:0];
	assign pixelOn = vidData[bitSel];

	// Colour and sync move together, one pixel behind the counters.
	always_ff @(posedge clk) begin
		if (!rstN) begin
			vgaR <= '0;
			vgaG <= '0;
			vgaB <= '0;
			vgaHs <= 1'b1;
			vgaVs <= 1'b1;
			vgaSyncN <= 1'b1;
			vgaBlankN <= 1'b0;
		end else if (pixelEn) begin
			vgaHs <= hSync;
			vgaVs <= vSync;
			vgaSyncN <= hSync & vSync;
			vgaBlankN <= bright;
			if (!bright) begin
				vgaR <= '0;
				vgaG <= '0;
				vgaB <= '0;
			end else if (pixelOn) begin
				vgaR <= 8'hFF;
				vgaG <= 8'hFF;
				vgaB <= 8'hFF;
			end else begin
				vgaR <= '0;
				vgaG <= '0;
				vgaB <= BG_BLUE;
			end
		end
	end

endmodule

//--- verilog/sharedMemory.sv
/*
 * Shared dual-port word memory.
 * Processor port with switch input and audio output words
 * mapped at the top of the address space, plus a read-only
 * video port. Both ports read with one clock of latency.
 */
`timescale 1ns/1ps

module sharedMemory #(
	parameter int MEM_WORDS = 512
) (
	input logic clk,
	input logic rstN,
	memBusIf.slave bus,
	input logic [15:0] vidAddr,
	output logic [15:0] vidData,
	input logic [9:0] switches,
	output logic [15:0] audioOut
);
	import tronPkg::*;

	localparam int ADDR_W = $clog2(MEM_WORDS);

	logic [15:0] ram [MEM_WORDS];
	logic isSwitch;
	logic isAudio;

	// Clear the whole array, then lay the program over it.
	initial begin
		for (int i = 0; i < MEM_WORDS; i++) begin
			ram[i] = '0;
		end
		$readmemh("test/program.hex", ram);
	end

	assign isSwitch = (bus.addr == ioSwitchAddr);
	assign isAudio = (bus.addr == ioAudioAddr);

	// Processor port.
	always_ff @(posedge clk) begin
		if (bus.we && !isSwitch && !isAudio) begin
			ram[bus.addr[ADDR_W-1:0]] <= bus.wdata;
		end
		if (isSwitch) begin
			bus.rdata <= {6'b000000, switches};
		end else if (isAudio) begin
			bus.rdata <= audioOut;
		end else begin
			bus.rdata <= ram[bus.addr[ADDR_W-1:0]];
		end
	end

	// Audio word, loaded by a store to its address.
	always_ff @(posedge clk) begin
		if (!rstN) begin
			audioOut <= '0;
		end else if (bus.we && isAudio) begin
			audioOut <= bus.wdata;
		end
	end

	// Video port, read only.
	always_ff @(posedge clk) begin
		vidData <= ram[vidAddr[ADDR_W-1:0]];
	end

	// The switch word is input only.
	assert property (@(posedge clk) disable iff (!rstN)
		!(bus.we && isSwitch));

endmodule

//--- verilog/tronPkg.sv
/*
 * Tron processor package.
 * Opcodes, the two-view instruction word, ALU operations
 * and the memory map shared by the processor and the memory.
 */
package tronPkg;

	// Instruction opcodes, top nibble of every word.
	typedef enum logic [3:0] {
		OP_ADD   = 4'h0,
		OP_SUB   = 4'h1,
		OP_AND   = 4'h2,
		OP_OR    = 4'h3,
		OP_XOR   = 4'h4,
		OP_SHL   = 4'h5,
		OP_ADDI  = 4'h6,
		OP_LUI   = 4'h7,
		OP_LOAD  = 4'h8,
		OP_STORE = 4'h9,
		OP_JMP   = 4'hA,
		OP_BEQ   = 4'hB
	} opcode_t;

	// One instruction word, read as register or immediate format.
	typedef union packed {
		struct packed {
			opcode_t opcode;
			logic [3:0] rd;
			logic [3:0] rs;
			logic [3:0] unused;
		} rType;
		struct packed {
			opcode_t opcode;
			logic [3:0] rd;
			logic [7:0] imm;
		} iType;
	} instrWord_t;

	// Datapath ALU operations.
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SHL = 3'd5,
		ALU_LUI = 3'd6
	} aluOp_t;

	// Memory map.
	localparam logic [15:0] ioSwitchAddr = 16'hFFFF;
	localparam logic [15:0] ioAudioAddr = 16'hFFFE;
	localparam logic [15:0] fbBase = 16'h0100;

endpackage

//--- verilog/tronTop.sv
/*
 * Tron system top level.
 * Multicycle processor, shared memory and one-bit video
 * output, wired to the board switches, audio word and VGA pins.
 */
`timescale 1ns/1ps

module tronTop #(
	parameter int MEM_WORDS = 512,
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT = 10,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 33
) (
	input logic clk,
	input logic rstN,
	input logic [9:0] switches,
	output logic [15:0] audioOut,
	output logic vgaHs,
	output logic vgaVs,
	output logic vgaClk,
	output logic vgaSyncN,
	output logic vgaBlankN,
	output logic [7:0] vgaR,
	output logic [7:0] vgaG,
	output logic [7:0] vgaB
);
	logic pixelEn;
	logic [15:0] hCount;
	logic [15:0] vCount;
	logic hSync;
	logic vSync;
	logic bright;
	logic [15:0] vidAddr;
	logic [15:0] vidData;

	cpuCtrlIf ctrlIf_i ();
	memBusIf memBus_i ();

	// Processor.
	cpuController ctrl_i (.clk(clk), .rstN(rstN), .bus(memBus_i.fetch), .ctrl(ctrlIf_i.ctrl));
	cpuDatapath dp_i (.clk(clk), .rstN(rstN), .ctrl(ctrlIf_i.dp), .bus(memBus_i.master));

	sharedMemory #(.MEM_WORDS(MEM_WORDS)) mem_i (
		.clk(clk), .rstN(rstN), .bus(memBus_i.slave), .vidAddr(vidAddr),
		.vidData(vidData), .switches(switches), .audioOut(audioOut)
	);

	// Video.
	videoTiming #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
	) timing_i (
		.clk(clk), .rstN(rstN), .pixelEn(pixelEn), .hCount(hCount), .vCount(vCount),
		.hSync(hSync), .vSync(vSync), .bright(bright)
	);

	pixelGen #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) pixel_i (
		.clk(clk), .rstN(rstN), .pixelEn(pixelEn), .hCount(hCount), .vCount(vCount),
		.bright(bright), .hSync(hSync), .vSync(vSync), .vidAddr(vidAddr),
		.vidData(vidData), .vgaR(vgaR), .vgaG(vgaG), .vgaB(vgaB), .vgaHs(vgaHs),
		.vgaVs(vgaVs), .vgaSyncN(vgaSyncN), .vgaBlankN(vgaBlankN)
	);

	// Pixel clock to the DAC.
	assign vgaClk = pixelEn;

endmodule

//--- verilog/videoTiming.sv
/*
 * Video timing generator.
 * Half-rate pixel enable, pixel and line counters with the
 * origin on the first visible pixel, and active-low sync
 * plus bright windows decoded from the counters.
 */
`timescale 1ns/1ps

module videoTiming #(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT = 10,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 33
) (
	input logic clk,
	input logic rstN,
	output logic pixelEn,
	output logic [15:0] hCount,
	output logic [15:0] vCount,
	output logic hSync,
	output logic vSync,
	output logic bright
);
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
	localparam int V_SYNC_START = V_ACTIVE + V_FRONT;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pixelEn <= 1'b0;
			hCount <= '0;
			vCount <= '0;
		end else begin
			// One pixel spans two clocks.
			pixelEn <= ~pixelEn;
			if (pixelEn) begin
				if (hCount == 16'(H_TOTAL - 1)) begin
					hCount <= '0;
					if (vCount == 16'(V_TOTAL - 1)) begin
						vCount <= '0;
					end else begin
						vCount <= vCount + 16'd1;
					end
				end else begin
					hCount <= hCount + 16'd1;
				end
			end
		end
	end

	// Sync pulses sit after the front porch.
	assign hSync = !((hCount >= 16'(H_SYNC_START)) && (hCount < 16'(H_SYNC_START + H_SYNC)));
	assign vSync = !((vCount >= 16'(V_SYNC_START)) && (vCount < 16'(V_SYNC_START + V_SYNC)));
	assign bright = (hCount < 16'(H_ACTIVE)) && (vCount < 16'(V_ACTIVE));

	// Visible area never overlaps the horizontal sync pulse.
	assert property (@(posedge clk) disable iff (!rstN)
		!(bright && !hSync));

endmodule
